// File: mipsPipeline.f
+incdir+bench
hdl/mipsPkg.sv
hdl/hazardUnit.sv
hdl/registerFile.sv
hdl/controlDecoder.sv
hdl/alu.sv
hdl/instructionMemory.sv
hdl/dataMemory.sv
hdl/pipelineDatapath.sv
hdl/mipsPipeline.sv
bench/mipsPipelineTb.sv

// File: Bender.yml
package:
  name: mips_pipeline

sources:
  - files:
      - hdl/mipsPkg.sv
      - hdl/hazardUnit.sv
      - hdl/registerFile.sv
      - hdl/controlDecoder.sv
      - hdl/alu.sv
      - hdl/instructionMemory.sv
      - hdl/dataMemory.sv
      - hdl/pipelineDatapath.sv
      - hdl/mipsPipeline.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/mipsPipelineTb.sv

// File: bench/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// Each entry holds a program, the register writes it must retire in order, and
// the code and argument of the first syscall it reports.
localparam int testCount = 5;
localparam int maxWords = 16;

// MIPS encodings of the supported subset.
localparam logic [5:0] opAddi = 6'h08;
localparam logic [5:0] opLw = 6'h23;
localparam logic [5:0] opSw = 6'h2b;
localparam logic [5:0] opBeq = 6'h04;
localparam logic [5:0] opBne = 6'h05;
localparam logic [5:0] fAdd = 6'h20;
localparam logic [5:0] fSub = 6'h22;
localparam logic [5:0] fAnd = 6'h24;
localparam logic [5:0] fOr = 6'h25;
localparam logic [5:0] fSlt = 6'h2a;
localparam logic [31:0] syscallWord = 32'h0000_000c;

// Register numbers used by the programs.
localparam logic [4:0] zero = 5'd0;
localparam logic [4:0] v0 = 5'd2;
localparam logic [4:0] a0 = 5'd4;
localparam logic [4:0] t0 = 5'd8;
localparam logic [4:0] t1 = 5'd9;
localparam logic [4:0] t2 = 5'd10;
localparam logic [4:0] t3 = 5'd11;
localparam logic [4:0] t4 = 5'd12;
localparam logic [4:0] t5 = 5'd13;
localparam logic [4:0] t6 = 5'd14;
localparam logic [4:0] t7 = 5'd15;

// One retired register write, as seen on the writeback strobe.
typedef struct packed {
	logic [4:0] regNum;
	logic [31:0] value;
} regWriteT;

string testName [testCount];
logic [31:0] programWords [testCount][maxWords];
int programLength [testCount];
regWriteT expectedWrites [testCount][maxWords];
int expectedWriteCount [testCount];
logic [31:0] expectedCode [testCount];
logic [31:0] expectedArg [testCount];
int entryIndex = -1;

function automatic logic [31:0] rWord(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
	return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic beginEntry(input string name, input logic [31:0] code,
		input logic [31:0] arg);
	entryIndex++;
	testName[entryIndex] = name;
	programLength[entryIndex] = 0;
	expectedWriteCount[entryIndex] = 0;
	expectedCode[entryIndex] = code;
	expectedArg[entryIndex] = arg;
endtask

// A destination of zero means the instruction must not show up on the strobe.
task automatic appendInstruction(input logic [31:0] word, input logic [4:0] dest,
		input logic [31:0] value);
	programWords[entryIndex][programLength[entryIndex]] = word;
	programLength[entryIndex]++;
	if (dest != zero) begin
		expectedWrites[entryIndex][expectedWriteCount[entryIndex]] = {dest, value};
		expectedWriteCount[entryIndex]++;
	end
endtask

// Every program ends by loading the exit code into v0 and calling syscall.
task automatic appendExit();
	appendInstruction(iWord(opAddi, v0, zero, 16'd10), v0, 32'd10);
	appendInstruction(syscallWord, zero, 32'd0);
endtask

task automatic buildTable();
	// Each ALU result feeds the next, from Memory and from Writeback.
	beginEntry("aluForwarding", 32'd10, 32'd0);
	appendInstruction(iWord(opAddi, t0, zero, 16'd5), t0, 32'd5);
	appendInstruction(iWord(opAddi, t1, zero, -16'd3), t1, 32'hffff_fffd);
	appendInstruction(rWord(fAdd, t2, t0, t1), t2, 32'd2);
	appendInstruction(rWord(fSub, t3, t2, t0), t3, 32'hffff_fffd);
	appendInstruction(rWord(fAnd, t4, t3, t0), t4, 32'd5);
	appendInstruction(rWord(fOr, t5, t4, t1), t5, 32'hffff_fffd);
	appendInstruction(rWord(fSlt, t6, t1, t4), t6, 32'd1);
	appendInstruction(rWord(fSlt, t7, t4, t1), t7, 32'd0);
	appendExit();
	// Store then load the same word; the add right after a load must stall.
	beginEntry("loadStore", 32'd10, 32'd0);
	appendInstruction(iWord(opAddi, t0, zero, 16'h0040), t0, 32'h0000_0040);
	appendInstruction(iWord(opAddi, t1, zero, 16'h1234), t1, 32'h0000_1234);
	appendInstruction(iWord(opSw, t1, t0, 16'd4), zero, 32'd0);
	appendInstruction(iWord(opLw, t2, t0, 16'd4), t2, 32'h0000_1234);
	appendInstruction(rWord(fAdd, t3, t2, t2), t3, 32'h0000_2468);
	appendInstruction(iWord(opSw, t3, t0, 16'd0), zero, 32'd0);
	appendInstruction(iWord(opLw, t4, t0, 16'd0), t4, 32'h0000_2468);
	appendExit();
	// Taken branches skip one addi each, and those must never write.
	beginEntry("branches", 32'd10, 32'd0);
	appendInstruction(iWord(opAddi, t0, zero, 16'd3), t0, 32'd3);
	appendInstruction(iWord(opAddi, t1, zero, 16'd3), t1, 32'd3);
	appendInstruction(iWord(opBeq, t1, t0, 16'd1), zero, 32'd0);
	appendInstruction(iWord(opAddi, t2, zero, 16'd1), zero, 32'd0);
	appendInstruction(iWord(opBne, t1, t0, 16'd1), zero, 32'd0);
	appendInstruction(iWord(opAddi, t3, zero, 16'd7), t3, 32'd7);
	appendInstruction(rWord(fSub, t4, t3, t0), t4, 32'd4);
	appendInstruction(iWord(opBne, zero, t4, 16'd1), zero, 32'd0);
	appendInstruction(iWord(opAddi, t5, zero, 16'd9), zero, 32'd0);
	appendInstruction(iWord(opBeq, t0, t4, 16'd1), zero, 32'd0);
	appendInstruction(iWord(opAddi, t6, zero, 16'd2), t6, 32'd2);
	appendExit();
	// The first syscall sees v0 and a0 written just before it.
	beginEntry("syscallReport", 32'd5, 32'h0000_0077);
	appendInstruction(iWord(opAddi, v0, zero, 16'd5), v0, 32'd5);
	appendInstruction(iWord(opAddi, a0, zero, 16'h0077), a0, 32'h0000_0077);
	appendInstruction(syscallWord, zero, 32'd0);
	appendExit();
	// Register zero stays zero, and the two words after the exit never retire.
	beginEntry("zeroAndHalt", 32'd10, 32'd7);
	appendInstruction(iWord(opAddi, zero, zero, 16'd9), zero, 32'd0);
	appendInstruction(iWord(opAddi, t0, zero, 16'd6), t0, 32'd6);
	appendInstruction(rWord(fAdd, zero, t0, t0), zero, 32'd0);
	appendInstruction(rWord(fAdd, t1, zero, t0), t1, 32'd6);
	appendInstruction(iWord(opAddi, a0, t1, 16'd1), a0, 32'd7);
	appendExit();
	appendInstruction(iWord(opAddi, t2, zero, 16'd1), zero, 32'd0);
	appendInstruction(iWord(opAddi, t3, zero, 16'd2), zero, 32'd0);
endtask

`endif

// File: bench/mipsPipelineTb.sv
`default_nettype none

module mipsPipelineTb;

	logic clk;
	logic reset;
	logic loadEnable;
	logic [31:0] loadAddr;
	logic [31:0] loadData;
	logic writeValid;
	logic [4:0] writeReg;
	logic [31:0] writeData;
	logic syscallValid;
	logic [31:0] syscallCode;
	logic [31:0] syscallArg;
	logic halted;

	`include "programTable.svh"

	// A run that has not halted after this many cycles is a failure.
	localparam int timeoutCycles = 400;
	// Instructions older than the exit syscall retire within a few cycles of the halt.
	localparam int drainCycles = 8;

	int errorCount;
	integer seed;
	int currentTest;
	int writesSeen;
	int syscallsSeen;

	mipsPipeline #(
		.imemDepth(256),
		.dmemDepth(256)
	) mipsPipeline_i (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	task automatic compareValue(input string signalName, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got %h, expected %h", signalName, actual, expected);
			errorCount++;
		end
	endtask

	task automatic reportFailure(input string message);
		$display("%s", message);
		errorCount++;
	endtask

	// Outputs are sampled on the falling edge, half a cycle after they settle.
	// Writes are matched in order against the table; extra writes only count.
	task automatic observeOutputs();
		regWriteT expected;
		if (writeValid) begin
			if (writesSeen < expectedWriteCount[currentTest]) begin
				expected = expectedWrites[currentTest][writesSeen];
				compareValue("writeReg", writeReg, expected.regNum);
				compareValue("writeData", writeData, expected.value);
			end
			writesSeen++;
		end
		if (syscallValid) begin
			if (syscallsSeen == 0) begin
				compareValue("syscallCode", syscallCode, expectedCode[currentTest]);
				compareValue("syscallArg", syscallArg, expectedArg[currentTest]);
			end
			syscallsSeen++;
		end
	endtask

	task automatic runTest(input int index);
		int i;
		int cycles;
		int errorsBefore;
		errorsBefore = errorCount;
		currentTest = index;
		writesSeen = 0;
		syscallsSeen = 0;
		// The core stays in reset for 16 cycles while one word loads per cycle.
		// Words past the program are random and sit behind the exit syscall.
		for (i = 0; i < maxWords; i++) begin
			@(negedge clk);
			reset = 1'b1;
			loadEnable = 1'b1;
			loadAddr = i;
			loadData = (i < programLength[index]) ? programWords[index][i] : $random(seed);
		end
		@(negedge clk);
		reset = 1'b0;
		loadEnable = 1'b0;
		loadAddr = '0;
		loadData = '0;
		cycles = 0;
		while (!halted && (cycles < timeoutCycles)) begin
			@(negedge clk);
			cycles++;
			observeOutputs();
		end
		if (!halted) begin
			reportFailure($sformatf("%s: the core did not halt within %0d cycles",
				testName[index], timeoutCycles));
		end else begin
			// Let the older instructions drain, and make sure the halt holds.
			for (i = 0; i < drainCycles; i++) begin
				@(negedge clk);
				observeOutputs();
				compareValue("halted", halted, 32'd1);
			end
		end
		if (writesSeen != expectedWriteCount[index]) begin
			reportFailure($sformatf("%s: saw %0d register writes where %0d were expected",
				testName[index], writesSeen, expectedWriteCount[index]));
		end
		if (syscallsSeen == 0) begin
			reportFailure($sformatf("%s: no syscall was reported", testName[index]));
		end
		$display("%s: %0d writes in %0d cycles, %s", testName[index], writesSeen, cycles,
			(errorCount == errorsBefore) ? "ok" : "FAILED");
	endtask

	initial begin
		int t;
		errorCount = 0;
		seed = 75;
		reset = 1'b1;
		loadEnable = 1'b0;
		loadAddr = '0;
		loadData = '0;
		buildTable();
		for (t = 0; t < testCount; t++) begin
			runTest(t);
		end
		$display("%0d tests run, %0d failed checks", testCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/mipsPipeline.sv
`default_nettype none

module mipsPipeline #(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 256
) (
	input wire clk,
	input wire reset,
	input wire loadEnable,
	input wire [31:0] loadAddr,
	input wire [31:0] loadData,
	output logic writeValid,
	output logic [4:0] writeReg,
	output logic [31:0] writeData,
	output logic syscallValid,
	output logic [31:0] syscallCode,
	output logic [31:0] syscallArg,
	output logic halted
);
	import mipsPkg::*;

	// Fetch, register file and decoder.
	logic [31:0] pc, instruction;
	logic [31:0] regReadDataA, regReadDataB;
	opcodeT opcode;
	functT funct;
	controlT control;

	// ALU and data memory.
	logic [31:0] operandA, operandB, aluResult;
	aluOpT aluOp;
	logic [31:0] memAddress, memWriteData, memReadData;
	logic memWriteEnable;

	// Hazard unit inputs and results.
	logic [4:0] rsDecode, rtDecode, rsExecute, rtExecute;
	logic [4:0] writeRegExecute, writeRegMemory, writeRegWriteback;
	logic branchDecode, syscallDecode;
	logic memToRegExecute, regWriteExecute, memToRegMemory, regWriteMemory;
	logic regWriteWriteback;
	logic stallFetch, stallDecode, flushExecute;
	logic forwardDecodeA, forwardDecodeB;
	logic [1:0] forwardExecuteA, forwardExecuteB;

	// Programs may only be written while the core is held in reset.
	logic imemLoadEnable;
	assign imemLoadEnable = loadEnable && reset;

	pipelineDatapath pipelineDatapath_i (.*);

	hazardUnit hazardUnit_i (.*);

	controlDecoder controlDecoder_i (.*);

	alu alu_i (
		.operandA(operandA),
		.operandB(operandB),
		.aluOp(aluOp),
		.result(aluResult)
	);

	// Decode reads through the hazard register numbers and Writeback writes back.
	registerFile registerFile_i (
		.clk,
		.reset,
		.readAddrA(rsDecode),
		.readAddrB(rtDecode),
		.writeEnable(regWriteWriteback),
		.writeAddr(writeRegWriteback),
		.writeData(writeData),
		.readDataA(regReadDataA),
		.readDataB(regReadDataB)
	);

	instructionMemory #(.imemDepth(imemDepth)) instructionMemory_i (
		.clk,
		.loadEnable(imemLoadEnable),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.readAddr(pc),
		.instruction(instruction)
	);

	dataMemory #(.dmemDepth(dmemDepth)) dataMemory_i (
		.clk,
		.writeEnable(memWriteEnable),
		.address(memAddress),
		.writeData(memWriteData),
		.readData(memReadData)
	);

endmodule

`default_nettype wire

// File: hdl/pipelineDatapath.sv
`default_nettype none

module pipelineDatapath (
	input wire clk,
	input wire reset,
	output logic [31:0] pc,
	input wire [31:0] instruction,
	input wire [31:0] regReadDataA, regReadDataB,
	output mipsPkg::opcodeT opcode,
	output mipsPkg::functT funct,
	input wire mipsPkg::controlT control,
	output logic [31:0] operandA, operandB,
	output mipsPkg::aluOpT aluOp,
	input wire [31:0] aluResult,
	output logic [31:0] memAddress, memWriteData,
	output logic memWriteEnable,
	input wire [31:0] memReadData,
	output logic [4:0] rsDecode, rtDecode,
	output logic branchDecode, syscallDecode,
	output logic [4:0] rsExecute, rtExecute, writeRegExecute,
	output logic memToRegExecute, regWriteExecute,
	output logic [4:0] writeRegMemory,
	output logic memToRegMemory, regWriteMemory,
	output logic [4:0] writeRegWriteback,
	output logic regWriteWriteback,
	input wire stallFetch, stallDecode, flushExecute,
	input wire forwardDecodeA, forwardDecodeB,
	input wire [1:0] forwardExecuteA, forwardExecuteB,
	output logic writeValid,
	output logic [4:0] writeReg,
	output logic [31:0] writeData,
	output logic syscallValid,
	output logic [31:0] syscallCode, syscallArg,
	output logic halted
);
	import mipsPkg::*;

	// Fetch to Decode register. An all-zero word decodes as a bubble.
	logic [31:0] decodeInstr;
	logic [31:0] decodePcPlus4;
	decodeExecuteT decodeExecute;
	executeMemoryT executeMemory;
	memoryWritebackT memoryWriteback;

	logic [31:0] immediate, branchTarget;
	logic [31:0] branchA, branchB;
	logic [31:0] executeA, executeB;
	logic branchTaken;
	logic exitTaken;

	// A syscall has no register fields, so Decode reads v0 and a0 in their place.
	assign opcode = opcodeT'(decodeInstr[31:26]);
	assign funct = functT'(decodeInstr[5:0]);
	assign rsDecode = control.syscall ? regV0 : decodeInstr[25:21];
	assign rtDecode = control.syscall ? regA0 : decodeInstr[20:16];
	assign branchDecode = control.branch;
	assign syscallDecode = control.syscall;
	assign immediate = {{16{decodeInstr[15]}}, decodeInstr[15:0]};

	// Branches resolve here, with ALU results forwarded back from Memory.
	assign branchTarget = decodePcPlus4 + {immediate[29:0], 2'b00};
	assign branchA = forwardDecodeA ? executeMemory.aluResult : regReadDataA;
	assign branchB = forwardDecodeB ? executeMemory.aluResult : regReadDataB;
	assign branchTaken = control.branch && !stallDecode &&
		((branchA != branchB) == control.branchNotEqual);

	// The syscall reports as it leaves Decode, once the hazard unit lets it go.
	assign syscallValid = control.syscall && !stallDecode;
	assign syscallCode = regReadDataA;
	assign syscallArg = regReadDataB;
	assign exitTaken = syscallValid && (regReadDataA == exitCode);

	// A taken branch or an exit squashes the word just fetched.
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			decodeInstr <= '0;
			decodePcPlus4 <= '0;
		end else begin
			if (!stallFetch && !halted) begin
				pc <= branchTaken ? branchTarget : pc + 32'd4;
			end
			if (!stallDecode) begin
				decodeInstr <= (branchTaken || exitTaken || halted) ? '0 : instruction;
				decodePcPlus4 <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			halted <= 1'b0;
		end else if (exitTaken) begin
			halted <= 1'b1;
		end
	end

	// Stalls leave a bubble here while Decode holds its instruction.
	always_ff @(posedge clk) begin
		if (reset || flushExecute) begin
			decodeExecute <= '0;
		end else begin
			decodeExecute.control <= control;
			decodeExecute.rs <= rsDecode;
			decodeExecute.rt <= rtDecode;
			decodeExecute.writeReg <= control.regDstRt ? decodeInstr[20:16] : decodeInstr[15:11];
			decodeExecute.readDataA <= regReadDataA;
			decodeExecute.readDataB <= regReadDataB;
			decodeExecute.immediate <= immediate;
		end
	end

	// Select 2 takes Memory, 1 takes Writeback, 0 keeps the register file value.
	assign executeA = (forwardExecuteA == 2'd2) ? executeMemory.aluResult :
		(forwardExecuteA == 2'd1) ? memoryWriteback.result : decodeExecute.readDataA;
	assign executeB = (forwardExecuteB == 2'd2) ? executeMemory.aluResult :
		(forwardExecuteB == 2'd1) ? memoryWriteback.result : decodeExecute.readDataB;

	assign operandA = executeA;
	assign operandB = decodeExecute.control.aluSrcImm ? decodeExecute.immediate : executeB;
	assign aluOp = decodeExecute.control.aluOp;
	assign rsExecute = decodeExecute.rs;
	assign rtExecute = decodeExecute.rt;
	assign writeRegExecute = decodeExecute.writeReg;
	assign memToRegExecute = decodeExecute.control.memToReg;
	assign regWriteExecute = decodeExecute.control.regWrite;

	// The store data is the forwarded rt value, not the immediate operand.
	always_ff @(posedge clk) begin
		if (reset) begin
			executeMemory <= '0;
		end else begin
			executeMemory.regWrite <= decodeExecute.control.regWrite;
			executeMemory.memToReg <= decodeExecute.control.memToReg;
			executeMemory.memWrite <= decodeExecute.control.memWrite;
			executeMemory.writeReg <= decodeExecute.writeReg;
			executeMemory.aluResult <= aluResult;
			executeMemory.writeData <= executeB;
		end
	end

	assign memAddress = executeMemory.aluResult;
	assign memWriteData = executeMemory.writeData;
	assign memWriteEnable = executeMemory.memWrite;
	assign writeRegMemory = executeMemory.writeReg;
	assign memToRegMemory = executeMemory.memToReg;
	assign regWriteMemory = executeMemory.regWrite;

	always_ff @(posedge clk) begin
		if (reset) begin
			memoryWriteback <= '0;
		end else begin
			memoryWriteback.regWrite <= executeMemory.regWrite;
			memoryWriteback.writeReg <= executeMemory.writeReg;
			memoryWriteback.result <= executeMemory.memToReg ? memReadData :
				executeMemory.aluResult;
		end
	end

	// Writes to register zero are dropped and never reported.
	assign writeRegWriteback = memoryWriteback.writeReg;
	assign regWriteWriteback = memoryWriteback.regWrite;
	assign writeReg = memoryWriteback.writeReg;
	assign writeData = memoryWriteback.result;
	assign writeValid = memoryWriteback.regWrite && (memoryWriteback.writeReg != 5'd0);

endmodule

`default_nettype wire

// File: hdl/dataMemory.sv
`default_nettype none

module dataMemory #(
	parameter int dmemDepth = 256
) (
	input wire clk,
	input wire writeEnable,
	input wire [31:0] address,
	input wire [31:0] writeData,
	output logic [31:0] readData
);

	localparam int indexWidth = $clog2(dmemDepth);

	logic [31:0] memory [dmemDepth];
	logic [indexWidth-1:0] index;

	// Depth is a power of two, so dropping the upper address bits wraps the
	// word address modulo the depth.
	assign index = address[indexWidth+1:2];

	always_ff @(posedge clk) begin
		if (writeEnable) begin
			memory[index] <= writeData;
		end
	end

	assign readData = memory[index];

endmodule

`default_nettype wire

// File: hdl/instructionMemory.sv
`default_nettype none

module instructionMemory #(
	parameter int imemDepth = 256
) (
	input wire clk,
	input wire loadEnable,
	input wire [31:0] loadAddr,
	input wire [31:0] loadData,
	input wire [31:0] readAddr,
	output logic [31:0] instruction
);

	localparam int indexWidth = $clog2(imemDepth);

	logic [31:0] memory [imemDepth];
	logic [29:0] readWord;

	// The load port takes a word index, so programs load one word per cycle.
	always_ff @(posedge clk) begin
		if (loadEnable && (loadAddr < imemDepth)) begin
			memory[loadAddr[indexWidth-1:0]] <= loadData;
		end
	end

	// The PC is a byte address. Fetch past the end returns zero, a no-operation.
	assign readWord = readAddr[31:2];
	assign instruction = (readWord < imemDepth) ? memory[readWord[indexWidth-1:0]] : '0;

endmodule

`default_nettype wire

// File: hdl/alu.sv
`default_nettype none

module alu (
	input wire [31:0] operandA,
	input wire [31:0] operandB,
	input wire mipsPkg::aluOpT aluOp,
	output logic [31:0] result
);
	import mipsPkg::*;

	always_comb begin
		case (aluOp)
			aluAdd: result = operandA + operandB;
			aluSub: result = operandA - operandB;
			aluAnd: result = operandA & operandB;
			aluOr: result = operandA | operandB;
			// Two's complement comparison, as slt is a signed compare.
			aluSlt: result = ($signed(operandA) < $signed(operandB)) ? 32'd1 : 32'd0;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/controlDecoder.sv
`default_nettype none

module controlDecoder (
	input wire mipsPkg::opcodeT opcode,
	input wire mipsPkg::functT funct,
	output mipsPkg::controlT control
);
	import mipsPkg::*;

	always_comb begin
		// Anything not listed below falls through as a no-operation.
		control = '0;
		control.aluOp = aluAdd;
		case (opcode)
			rType: begin
				control.regWrite = 1'b1;
				case (funct)
					functAdd: control.aluOp = aluAdd;
					functSub: control.aluOp = aluSub;
					functAnd: control.aluOp = aluAnd;
					functOr: control.aluOp = aluOr;
					functSlt: control.aluOp = aluSlt;
					functSyscall: begin
						control.regWrite = 1'b0;
						control.syscall = 1'b1;
					end
					default: control.regWrite = 1'b0;
				endcase
			end
			addi: begin
				control.regWrite = 1'b1;
				control.aluSrcImm = 1'b1;
				control.regDstRt = 1'b1;
			end
			lw: begin
				control.regWrite = 1'b1;
				control.memToReg = 1'b1;
				control.aluSrcImm = 1'b1;
				control.regDstRt = 1'b1;
			end
			sw: begin
				control.memWrite = 1'b1;
				control.aluSrcImm = 1'b1;
			end
			beq: control.branch = 1'b1;
			bne: begin
				control.branch = 1'b1;
				control.branchNotEqual = 1'b1;
			end
			default: control = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`default_nettype none

module registerFile (
	input wire clk,
	input wire reset,
	input wire [4:0] readAddrA, readAddrB,
	input wire writeEnable,
	input wire [4:0] writeAddr,
	input wire [31:0] writeData,
	output logic [31:0] readDataA, readDataB
);

	logic [31:0] registers [32];

	// Register zero is never written, so it keeps its reset value.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				registers[i] <= '0;
			end
		end else if (writeEnable && (writeAddr != 5'd0)) begin
			registers[writeAddr] <= writeData;
		end
	end

	// A read of the register being written this cycle sees the new value.
	// This lets Writeback and Decode share a cycle without a hazard.
	assign readDataA = (readAddrA == 5'd0) ? '0 :
		(writeEnable && (writeAddr == readAddrA)) ? writeData : registers[readAddrA];
	assign readDataB = (readAddrB == 5'd0) ? '0 :
		(writeEnable && (writeAddr == readAddrB)) ? writeData : registers[readAddrB];

endmodule

`default_nettype wire

// File: hdl/hazardUnit.sv
`default_nettype none

module hazardUnit (
	input wire [4:0] rsDecode, rtDecode,
	input wire branchDecode,
	input wire syscallDecode,
	input wire [4:0] rsExecute, rtExecute, writeRegExecute,
	input wire memToRegExecute,
	input wire regWriteExecute,
	input wire [4:0] writeRegMemory,
	input wire memToRegMemory,
	input wire regWriteMemory,
	input wire [4:0] writeRegWriteback,
	input wire regWriteWriteback,
	output logic stallFetch,
	output logic stallDecode,
	output logic flushExecute,
	output logic forwardDecodeA, forwardDecodeB,
	output logic [1:0] forwardExecuteA, forwardExecuteB
);
	import mipsPkg::*;

	logic loadUseStall;
	logic branchStall;
	logic syscallStall;
	logic stall;

	// True when a stage with this write enable and destination produces the source.
	// Register zero is never a real dependency.
	function automatic logic produces(input logic enable, input logic [4:0] dest,
			input logic [4:0] source);
		return enable && (dest != 5'd0) && (dest == source);
	endfunction

	// True when a stage is about to write one of the two syscall registers.
	function automatic logic writesSyscallReg(input logic enable, input logic [4:0] dest);
		return enable && ((dest == regV0) || (dest == regA0));
	endfunction

	// A load in Execute has no data until Memory, so a dependent Decode must wait.
	assign loadUseStall = memToRegExecute &&
		(produces(regWriteExecute, writeRegExecute, rsDecode) ||
		produces(regWriteExecute, writeRegExecute, rtDecode));

	// Branches compare in Decode, so an ALU result still in Execute or a load
	// still in Memory is too late for them.
	assign branchStall = branchDecode &&
		(produces(regWriteExecute, writeRegExecute, rsDecode) ||
		produces(regWriteExecute, writeRegExecute, rtDecode) ||
		produces(memToRegMemory && regWriteMemory, writeRegMemory, rsDecode) ||
		produces(memToRegMemory && regWriteMemory, writeRegMemory, rtDecode));

	// A syscall reads v0 and a0 straight from the register file.
	// It waits until every older writer of those registers has retired.
	assign syscallStall = syscallDecode &&
		(writesSyscallReg(regWriteExecute, writeRegExecute) ||
		writesSyscallReg(regWriteMemory, writeRegMemory) ||
		writesSyscallReg(regWriteWriteback, writeRegWriteback));

	assign stall = loadUseStall || branchStall || syscallStall;

	// Fetch and Decode hold while Execute takes a bubble.
	assign stallFetch = stall;
	assign stallDecode = stall;
	assign flushExecute = stall;

	// Branch operands can take an ALU result from Memory.
	assign forwardDecodeA = produces(regWriteMemory, writeRegMemory, rsDecode);
	assign forwardDecodeB = produces(regWriteMemory, writeRegMemory, rtDecode);

	// Memory is younger than Writeback, so its value wins.
	assign forwardExecuteA = produces(regWriteMemory, writeRegMemory, rsExecute) ? 2'd2 :
		produces(regWriteWriteback, writeRegWriteback, rsExecute) ? 2'd1 : 2'd0;
	assign forwardExecuteB = produces(regWriteMemory, writeRegMemory, rtExecute) ? 2'd2 :
		produces(regWriteWriteback, writeRegWriteback, rtExecute) ? 2'd1 : 2'd0;

endmodule

`default_nettype wire

// File: hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// Primary opcode field, bits 31 to 26 of the instruction word.
	typedef enum logic [5:0] {
		rType = 6'h00,
		beq   = 6'h04,
		bne   = 6'h05,
		addi  = 6'h08,
		lw    = 6'h23,
		sw    = 6'h2b
	} opcodeT;

	// Function field of R-type instructions, bits 5 to 0.
	typedef enum logic [5:0] {
		functSyscall = 6'h0c,
		functAdd     = 6'h20,
		functSub     = 6'h22,
		functAnd     = 6'h24,
		functOr      = 6'h25,
		functSlt     = 6'h2a
	} functT;

	// Operation selected for the ALU in the Execute stage.
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

	// Registers read by a syscall, and the v0 value that stops the core.
	localparam logic [4:0] regV0 = 5'd2;
	localparam logic [4:0] regA0 = 5'd4;
	localparam logic [31:0] exitCode = 32'd10;

	// Control bits produced in Decode; an all-zero value is a bubble.
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrcImm;
		logic regDstRt;
		logic branch;
		logic branchNotEqual;
		logic syscall;
		aluOpT aluOp;
	} controlT;

	// Decode to Execute stage register.
	typedef struct packed {
		controlT control;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] writeReg;
		logic [31:0] readDataA;
		logic [31:0] readDataB;
		logic [31:0] immediate;
	} decodeExecuteT;

	// Execute to Memory stage register.
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic [4:0] writeReg;
		logic [31:0] aluResult;
		logic [31:0] writeData;
	} executeMemoryT;

	// Memory to Writeback stage register.
	typedef struct packed {
		logic regWrite;
		logic [4:0] writeReg;
		logic [31:0] result;
	} memoryWritebackT;

endpackage

`default_nettype wire
